// ==== all.f ====
source/motorPwmPkg.sv
source/commutationTimer.sv
source/stepDecoder.sv
source/pwmGenerator.sv
source/lostAccount.sv
source/gateDriveMux.sv
source/motorPwmTop.sv
test/motorPwmTb.sv

// ==== Makefile ====
TOP             ?= motorPwmTb
RTL_TOP         ?= motorPwmTop
FILELIST        ?= all.f
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --timescale 1ns/100ps -j 0
PASS_TEXT       ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall $(VERILATOR_FLAGS) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/motorPwmTb.sv ====
module motorPwmTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam motorPwmPkg::posT MIN_ON = 16'd256;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 20;
    localparam int TAIL_CYCLES   = 5;
    localparam int RANDOM_ROUNDS = 4;
    localparam int RANDOM_STEP_MAX = 1600;
    // fixed scenarios run two turns each, random rounds one turn each
    localparam int TEST_CYCLES = RESET_CYCLES + 2 * 6 * (2000 + 1601 + 1500)
        + RANDOM_ROUNDS * 6 * RANDOM_STEP_MAX
        + (4 + RANDOM_ROUNDS) * (IDLE_CYCLES + TAIL_CYCLES);
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;
    // one report per step
    localparam int EXPECTED_REPORTS = 3 * 2 * 6 + RANDOM_ROUNDS * 6;

    // software copy of every register in the DUT
    typedef struct packed {
        logic                    started;
        motorPwmPkg::posT        stepCnt;
        motorPwmPkg::stepT       step;
        logic                    first;
        logic                    last;
        motorPwmPkg::periodT     periodCnt;
        motorPwmPkg::posT        remain;
        motorPwmPkg::posT        pulseCnt;
        motorPwmPkg::posT        wantedAcc;
        motorPwmPkg::posT        deliveredAcc;
        motorPwmPkg::lostReportS report;
        logic [2:0]              gateHigh;
        logic [2:0]              gateLow;
    } modelStateS;

    logic                    clk;
    logic                    arstN;
    logic                    run;
    motorPwmPkg::posT        stepLen;
    motorPwmPkg::periodT     periodLen;
    motorPwmPkg::posT        dutyPos;
    logic [2:0]              gateHigh;
    logic [2:0]              gateLow;
    logic                    pwm;
    motorPwmPkg::lostReportS report;

    modelStateS mdl = '0;
    int seed = 32'hb716;
    int cycleCount = 0;
    int reportCount = 0;

    motorPwmTop #(
        .MIN_ON (MIN_ON)
    ) u_motorPwmTop (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .stepLen   (stepLen),
        .periodLen (periodLen),
        .dutyPos   (dutyPos),
        .gateHigh  (gateHigh),
        .gateLow   (gateLow),
        .pwm       (pwm),
        .report    (report)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // commutation order, bit 0 is phase A
    function automatic logic [2:0] highGateOf(input motorPwmPkg::stepT step);
        case (step)
            4'd0, 4'd1: return 3'b001;
            4'd2, 4'd3: return 3'b010;
            4'd4, 4'd5: return 3'b100;
            default:    return 3'b000;
        endcase
    endfunction

    function automatic logic [2:0] lowGateOf(input motorPwmPkg::stepT step);
        case (step)
            4'd0, 4'd5: return 3'b010;
            4'd1, 4'd2: return 3'b100;
            4'd3, 4'd4: return 3'b001;
            default:    return 3'b000;
        endcase
    endfunction

    function automatic modelStateS modelStep(input modelStateS s, input logic runIn,
                                             input motorPwmPkg::posT stepLenIn,
                                             input motorPwmPkg::periodT periodLenIn,
                                             input motorPwmPkg::posT dutyIn);
        modelStateS       n;
        logic             restart;
        logic             periodStart;
        logic             pwmNow;
        motorPwmPkg::posT sum;
        motorPwmPkg::posT periodPos;
        motorPwmPkg::posT cntNext;
        motorPwmPkg::posT wantedNow;
        motorPwmPkg::posT deliveredNow;
        motorPwmPkg::posT lostNow;
        n            = s;
        pwmNow       = (s.pulseCnt != 16'd0);
        periodStart  = runIn && (s.first || s.periodCnt == 12'd1);
        sum          = s.remain + dutyIn;
        periodPos    = {4'd0, periodLenIn};
        wantedNow    = s.wantedAcc + (periodStart ? dutyIn : 16'd0);
        deliveredNow = s.deliveredAcc + (pwmNow ? 16'd1 : 16'd0);
        lostNow      = wantedNow - deliveredNow;
        n.gateHigh   = (runIn && pwmNow) ? highGateOf(s.step) : 3'b000;
        n.gateLow    = runIn ? lowGateOf(s.step) : 3'b000;
        n.report.valid = runIn && s.last;
        if (runIn && s.last) begin
            n.report.step      = s.step;
            n.report.wanted    = wantedNow;
            n.report.delivered = deliveredNow;
            n.report.lost      = lostNow;
            n.report.lostTotal = (s.step == 4'd0) ? lostNow : s.report.lostTotal + lostNow;
        end
        if (!runIn) begin
            n.started      = 1'b0;
            n.stepCnt      = '0;
            n.step         = '0;
            n.first        = 1'b0;
            n.last         = 1'b0;
            n.periodCnt    = periodLenIn;
            n.remain       = '0;
            n.pulseCnt     = '0;
            n.wantedAcc    = '0;
            n.deliveredAcc = '0;
        end else begin
            restart   = !s.started || s.last;
            cntNext   = restart ? 16'd0 : s.stepCnt + 16'd1;
            n.started = 1'b1;
            n.stepCnt = cntNext;
            if (!s.started) begin
                n.step = '0;
            end else if (s.last) begin
                n.step = (s.step == 4'd5) ? 4'd0 : s.step + 4'd1;
            end
            n.first = restart;
            n.last  = (cntNext == stepLenIn - 16'd1);
            n.periodCnt = (s.first || s.periodCnt == 12'd1) ? periodLenIn
                                                            : s.periodCnt - 12'd1;
            // carry is lost at the step end even on a period start
            if (s.last) begin
                n.remain = '0;
            end else if (periodStart) begin
                n.remain = (sum < MIN_ON) ? sum : 16'd0;
            end
            if (periodStart && sum >= MIN_ON) begin
                n.pulseCnt = (sum < periodPos) ? sum : periodPos;
            end else if (pwmNow) begin
                n.pulseCnt = s.pulseCnt - 16'd1;
            end
            n.wantedAcc    = s.last ? 16'd0 : wantedNow;
            n.deliveredAcc = s.last ? 16'd0 : deliveredNow;
        end
        return n;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic runScenario(input motorPwmPkg::posT sLen, input motorPwmPkg::periodT pLen,
                               input motorPwmPkg::posT duty, input int turns);
        run       = 1'b0;
        stepLen   = sLen;
        periodLen = pLen;
        dutyPos   = duty;
        waitCycles(IDLE_CYCLES);
        run = 1'b1;
        waitCycles(turns * 6 * int'(sLen) + TAIL_CYCLES);
        run = 1'b0;
    endtask

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdl <= '0;
        end else begin
            mdl <= modelStep(mdl, run, stepLen, periodLen, dutyPos);
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        checkValue("gateHigh", 32'(gateHigh), 32'(mdl.gateHigh));
        checkValue("gateLow", 32'(gateLow), 32'(mdl.gateLow));
        checkValue("pwm", 32'(pwm), 32'(mdl.pulseCnt != 16'd0));
        checkValue("report.valid", 32'(report.valid), 32'(mdl.report.valid));
        if (mdl.report.valid) begin
            reportCount++;
            checkValue("report.step", 32'(report.step), 32'(mdl.report.step));
            checkValue("report.wanted", 32'(report.wanted), 32'(mdl.report.wanted));
            checkValue("report.delivered", 32'(report.delivered), 32'(mdl.report.delivered));
            checkValue("report.lost", 32'(report.lost), 32'(mdl.report.lost));
            checkValue("report.lostTotal", 32'(report.lostTotal), 32'(mdl.report.lostTotal));
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int r;
        motorPwmPkg::posT    sLen;
        motorPwmPkg::periodT pLen;
        motorPwmPkg::posT    duty;
        arstN     = 1'b0;
        run       = 1'b0;
        stepLen   = 16'd1000;
        periodLen = 12'd100;
        dutyPos   = 16'd0;
        waitCycles(RESET_CYCLES);
        arstN = 1'b1;
        // constant duty, then small duty with carry, then duty above the period
        runScenario(16'd2000, 12'd500, 16'd300, 2);
        // the last period start of each step lands on the step's last cycle
        runScenario(16'd1601, 12'd400, 16'd100, 2);
        runScenario(16'd1500, 12'd300, 16'd400, 2);
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            r    = $random(seed);
            sLen = motorPwmPkg::posT'(600 + ($unsigned(r) % 1000));
            r    = $random(seed);
            pLen = motorPwmPkg::periodT'(100 + ($unsigned(r) % 400));
            r    = $random(seed);
            duty = motorPwmPkg::posT'($unsigned(r) % 600);
            runScenario(sLen, pLen, duty, 1);
        end
        waitCycles(IDLE_CYCLES);
        checkValue("report count", 32'(reportCount), 32'(EXPECTED_REPORTS));
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== source/motorPwmTop.sv ====
module motorPwmTop #(
    parameter motorPwmPkg::posT MIN_ON = 16'd256
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    run,
    input  motorPwmPkg::posT        stepLen,
    input  motorPwmPkg::periodT     periodLen,
    input  motorPwmPkg::posT        dutyPos,
    output logic [2:0]              gateHigh,
    output logic [2:0]              gateLow,
    output logic                    pwm,
    output motorPwmPkg::lostReportS report
);

    motorPwmPkg::stepInfoS  stepInfo;
    motorPwmPkg::phaseCmdS  phaseCmd;
    motorPwmPkg::pwmStatusS pwmStatus;

    commutationTimer u_commutationTimer (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .stepLen  (stepLen),
        .stepInfo (stepInfo)
    );

    stepDecoder u_stepDecoder (
        .run      (run),
        .stepInfo (stepInfo),
        .phaseCmd (phaseCmd)
    );

    pwmGenerator #(
        .MIN_ON (MIN_ON)
    ) u_pwmGenerator (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .stepInfo  (stepInfo),
        .periodLen (periodLen),
        .dutyPos   (dutyPos),
        .status    (pwmStatus)
    );

    lostAccount u_lostAccount (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .stepInfo (stepInfo),
        .dutyPos  (dutyPos),
        .status   (pwmStatus),
        .report   (report)
    );

    gateDriveMux u_gateDriveMux (
        .clk      (clk),
        .arstN    (arstN),
        .phaseCmd (phaseCmd),
        .pwm      (pwmStatus.pwm),
        .gateHigh (gateHigh),
        .gateLow  (gateLow)
    );

    assign pwm = pwmStatus.pwm;

endmodule

// ==== source/gateDriveMux.sv ====
module gateDriveMux (
    input  logic                  clk,
    input  logic                  arstN,
    input  motorPwmPkg::phaseCmdS phaseCmd,
    input  logic                  pwm,
    output logic [2:0]            gateHigh,
    output logic [2:0]            gateLow
);

    logic [2:0] highNext;
    logic [2:0] lowNext;

    // only the high side is chopped, the low side conducts all step long
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            highNext[i] = phaseCmd.active && pwm
                && (phaseCmd.highPhase == motorPwmPkg::phaseSelT'(i));
            lowNext[i]  = phaseCmd.active
                && (phaseCmd.lowPhase == motorPwmPkg::phaseSelT'(i));
        end
    end

    // registered gates, all off after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            gateHigh <= '0;
            gateLow  <= '0;
        end else begin
            gateHigh <= highNext;
            gateLow  <= lowNext;
        end
    end

endmodule

// ==== source/lostAccount.sv ====
module lostAccount (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  motorPwmPkg::stepInfoS  stepInfo,
    input  motorPwmPkg::posT       dutyPos,
    input  motorPwmPkg::pwmStatusS status,
    output motorPwmPkg::lostReportS report
);

    motorPwmPkg::posT wantedAcc;
    motorPwmPkg::posT deliveredAcc;
    motorPwmPkg::posT wantedNow;
    motorPwmPkg::posT deliveredNow;
    motorPwmPkg::posT lostNow;
    motorPwmPkg::posT totalNow;

    // totals including this cycle, so the last cycle of a step counts
    assign wantedNow    = status.periodStart ? wantedAcc + dutyPos : wantedAcc;
    assign deliveredNow = status.pwm ? deliveredAcc + 16'd1 : deliveredAcc;
    assign lostNow      = wantedNow - deliveredNow;
    // running total over one turn, restarts with step 0
    assign totalNow     = (stepInfo.step == '0) ? lostNow : report.lostTotal + lostNow;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wantedAcc    <= '0;
            deliveredAcc <= '0;
        end else if (!run || stepInfo.last) begin
            wantedAcc    <= '0;
            deliveredAcc <= '0;
        end else begin
            wantedAcc    <= wantedNow;
            deliveredAcc <= deliveredNow;
        end
    end

    // one report per step, payload held until the next one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            report <= '0;
        end else begin
            report.valid <= run && stepInfo.last;
            if (run && stepInfo.last) begin
                report.step      <= stepInfo.step;
                report.wanted    <= wantedNow;
                report.delivered <= deliveredNow;
                report.lost      <= lostNow;
                report.lostTotal <= totalNow;
            end
        end
    end

endmodule

// ==== source/pwmGenerator.sv ====
module pwmGenerator #(
    parameter motorPwmPkg::posT MIN_ON = 16'd256
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   run,
    input  motorPwmPkg::stepInfoS  stepInfo,
    input  motorPwmPkg::periodT    periodLen,
    input  motorPwmPkg::posT       dutyPos,
    output motorPwmPkg::pwmStatusS status
);

    motorPwmPkg::periodT     periodCnt;
    motorPwmPkg::posT        pulseCnt;
    motorPwmPkg::posT        remain;
    motorPwmPkg::posT        posSum;
    motorPwmPkg::posT        periodLenPos;
    motorPwmPkg::posT        pulseLoad;
    motorPwmPkg::skipReasonE skipReason;
    logic                    periodStart;

    assign periodStart  = run && (stepInfo.first || periodCnt == 12'd1);

    // carried on-time plus this period's request
    assign posSum       = remain + dutyPos;
    assign periodLenPos = {4'd0, periodLen};
    // a pulse never outlasts its period
    assign pulseLoad    = (posSum < periodLenPos) ? posSum : periodLenPos;

    always_comb begin
        if (!run) begin
            skipReason = motorPwmPkg::skipNoActive;
        end else if (posSum < MIN_ON) begin
            skipReason = motorPwmPkg::skipMinLimit;
        end else begin
            skipReason = motorPwmPkg::skipNone;
        end
    end

    // period counter restarts on every step start
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else if (!run || stepInfo.first || periodCnt == 12'd1) begin
            periodCnt <= periodLen;
        end else begin
            periodCnt <= periodCnt - 12'd1;
        end
    end

    // short pulses are carried forward, the carry dies with the step
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            remain <= '0;
        end else if (!run || stepInfo.last) begin
            remain <= '0;
        end else if (periodStart) begin
            if (skipReason == motorPwmPkg::skipMinLimit) begin
                remain <= posSum;
            end else begin
                remain <= '0;
            end
        end
    end

    // pulse counter, pwm is high while it is nonzero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end else if (!run) begin
            pulseCnt <= '0;
        end else if (periodStart && skipReason == motorPwmPkg::skipNone) begin
            pulseCnt <= pulseLoad;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 16'd1;
        end
    end

    assign status.pwm         = (pulseCnt != '0);
    assign status.periodStart = periodStart;
    assign status.skip        = skipReason;

endmodule

// ==== source/stepDecoder.sv ====
module stepDecoder (
    input  logic                  run,
    input  motorPwmPkg::stepInfoS stepInfo,
    output motorPwmPkg::phaseCmdS phaseCmd
);

    localparam motorPwmPkg::phaseSelT PHASE_A = 2'd0;
    localparam motorPwmPkg::phaseSelT PHASE_B = 2'd1;
    localparam motorPwmPkg::phaseSelT PHASE_C = 2'd2;

    assign phaseCmd.active = run;

    // commutation order, high side first
    always_comb begin
        case (stepInfo.step)
            4'd0: begin
                phaseCmd.highPhase = PHASE_A;
                phaseCmd.lowPhase  = PHASE_B;
            end
            4'd1: begin
                phaseCmd.highPhase = PHASE_A;
                phaseCmd.lowPhase  = PHASE_C;
            end
            4'd2: begin
                phaseCmd.highPhase = PHASE_B;
                phaseCmd.lowPhase  = PHASE_C;
            end
            4'd3: begin
                phaseCmd.highPhase = PHASE_B;
                phaseCmd.lowPhase  = PHASE_A;
            end
            4'd4: begin
                phaseCmd.highPhase = PHASE_C;
                phaseCmd.lowPhase  = PHASE_A;
            end
            4'd5: begin
                phaseCmd.highPhase = PHASE_C;
                phaseCmd.lowPhase  = PHASE_B;
            end
            default: begin
                // unreachable, the timer wraps at 5
                phaseCmd.highPhase = PHASE_A;
                phaseCmd.lowPhase  = PHASE_B;
            end
        endcase
    end

endmodule

// ==== source/commutationTimer.sv ====
module commutationTimer (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  run,
    input  motorPwmPkg::posT      stepLen,
    output motorPwmPkg::stepInfoS stepInfo
);

    motorPwmPkg::posT  stepCnt;
    motorPwmPkg::posT  stepCntNext;
    motorPwmPkg::stepT stepNext;
    logic              started;
    logic              restart;

    // a step begins on the first running cycle and after every last
    assign restart     = !started || stepInfo.last;
    assign stepCntNext = restart ? '0 : stepCnt + 16'd1;

    // six electrical steps per turn
    always_comb begin
        if (stepInfo.last) begin
            if (stepInfo.step == 4'd5) begin
                stepNext = '0;
            end else begin
                stepNext = stepInfo.step + 4'd1;
            end
        end else begin
            stepNext = stepInfo.step;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            started        <= 1'b0;
            stepCnt        <= '0;
            stepInfo.step  <= '0;
            stepInfo.first <= 1'b0;
            stepInfo.last  <= 1'b0;
        end else if (!run) begin
            // idle, everything parked at step 0
            started        <= 1'b0;
            stepCnt        <= '0;
            stepInfo.step  <= '0;
            stepInfo.first <= 1'b0;
            stepInfo.last  <= 1'b0;
        end else begin
            started        <= 1'b1;
            stepCnt        <= stepCntNext;
            stepInfo.step  <= stepNext;
            // strobes are registered together with the count they frame
            stepInfo.first <= restart;
            stepInfo.last  <= (stepCntNext == stepLen - 16'd1);
        end
    end

endmodule

// ==== source/motorPwmPkg.sv ====
package motorPwmPkg;

    // pwm period length or period count in clock cycles
    typedef logic [11:0] periodT;

    // on-time amount or step length in clock cycles
    typedef logic [15:0] posT;

    // electrical step index, only 0 to 5 are used
    typedef logic [3:0] stepT;

    // phase number, A is 0, B is 1 and C is 2
    typedef logic [1:0] phaseSelT;

    // decision taken at every pwm period start
    typedef enum logic [1:0] {
        skipNone,
        skipMinLimit,
        skipNoActive
    } skipReasonE;

    // step framing from the commutation timer
    typedef struct packed {
        stepT step;
        logic first;
        logic last;
    } stepInfoS;

    // conducting phase pair of the current step
    typedef struct packed {
        logic     active;
        phaseSelT highPhase;
        phaseSelT lowPhase;
    } phaseCmdS;

    typedef struct packed {
        logic       pwm;
        logic       periodStart;
        skipReasonE skip;
    } pwmStatusS;

    // per-step on-time balance, lost wraps modulo 2^16
    typedef struct packed {
        logic valid;
        stepT step;
        posT  wanted;
        posT  delivered;
        posT  lost;
        posT  lostTotal;
    } lostReportS;

endpackage
